//--- source/fft_ctrl_config.svh
`ifndef FFT_CTRL_CONFIG_SVH
`define FFT_CTRL_CONFIG_SVH

// data and factor memory address, one word per block
`define FFT_DM_ADDR_W 4

// transpose memory address
`define FFT_TM_ADDR_W 4

// one bit per radix-2 stage
`define FFT_STAGE_W 7

// long enough for the 25-cycle pass of size 2048
`define FFT_PASS_CNT_W 5

`define FFT_FINISH_CNT_W 2

// idle level of all memory strobes (active low)
`define FFT_STROBE_IDLE 1'b1

`endif

//--- source/fft_ctrl_pkg.sv
`default_nettype none
`include "fft_ctrl_config.svh"

package fft_ctrl_pkg;

	typedef enum logic [2:0] {
		fft64   = 3'd0,
		fft128  = 3'd1,
		fft256  = 3'd2,
		fft512  = 3'd3,
		fft1024 = 3'd4,
		fft2048 = 3'd5
	} fft_size_e;

	typedef enum logic [2:0] {
		load_in,
		fft_pass,
		twiddle,
		transpose_pass,
		read_out
	} phase_e;

	// twiddle multiplier mode
	typedef enum logic [1:0] {
		radix16 = 2'd0,
		radix8  = 2'd1,
		radix4  = 2'd2,
		radix2  = 2'd3
	} radix_e;

	function automatic logic [`FFT_DM_ADDR_W:0] block_count(input fft_size_e size);
		case (size)
			fft256:  return 5'd2;
			fft512:  return 5'd4;
			fft1024: return 5'd8;
			fft2048: return 5'd16;
			default: return 5'd1; // 64 and 128 fit in one block
		endcase
	endfunction

	function automatic logic [`FFT_PASS_CNT_W-1:0] pass1_last(input fft_size_e size);
		case (size)
			fft64:   return 5'd8;
			fft128:  return 5'd9;
			fft256:  return 5'd10;
			fft512:  return 5'd12;
			fft1024: return 5'd16;
			default: return 5'd24;
		endcase
	endfunction

	// second pass only exists from 256 up
	function automatic logic [`FFT_PASS_CNT_W-1:0] pass3_last(input fft_size_e size);
		case (size)
			fft256:  return 5'd4;
			fft512:  return 5'd7;
			fft1024: return 5'd12;
			fft2048: return 5'd21;
			default: return 5'd0;
		endcase
	endfunction

	function automatic radix_e size_radix(input fft_size_e size);
		case (size)
			fft256:  return radix2;
			fft512:  return radix4;
			fft1024: return radix8;
			default: return radix16;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- source/phase_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module phase_sequencer
	import fft_ctrl_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire            ce_fft,
	input  wire fft_size_e fft_mode,
	input  wire            dm_last_block,
	input  wire            twiddle_done,
	output phase_e         phase,
	output logic           dm_block_run,
	output logic           tm_block_run,
	output logic           dm_wb_run,
	output logic           tm_wb_run,
	output logic           step_run,
	output logic           finish_fft_process
);

	phase_e phase_next;
	logic [`FFT_PASS_CNT_W-1:0] pass_cnt;
	logic [`FFT_FINISH_CNT_W-1:0] finish_cnt;
	logic small_size;

	assign small_size = (fft_mode == fft64) || (fft_mode == fft128);

	always_comb begin
		phase_next = phase;
		case (phase)
			load_in: begin
				if (dm_last_block) begin
					phase_next = fft_pass;
				end
			end
			fft_pass: begin
				if (pass_cnt == pass1_last(fft_mode)) begin
					// no second pass below 256 points
					phase_next = small_size ? read_out : twiddle;
				end
			end
			twiddle: begin
				if (twiddle_done) begin
					phase_next = transpose_pass;
				end
			end
			transpose_pass: begin
				if (pass_cnt == pass3_last(fft_mode)) begin
					phase_next = read_out;
				end
			end
			default: begin
				phase_next = read_out; // parked until reset
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase      <= load_in;
			pass_cnt   <= '0;
			finish_cnt <= '0;
		end else if (ce_fft) begin
			phase <= phase_next;

			if (phase_next != phase) begin
				pass_cnt <= '0;
			end else if (phase == fft_pass || phase == transpose_pass) begin
				pass_cnt <= pass_cnt + 1'b1;
			end

			// 0, 1, 2 then hold
			if (phase == read_out && finish_cnt != 2'd2) begin
				finish_cnt <= finish_cnt + 1'b1;
			end
		end
	end

	// dropping run on the last load block wraps the address back to 0
	assign dm_block_run = (phase == load_in && !dm_last_block) ||
		phase == fft_pass || phase == read_out;
	assign tm_block_run = (phase == transpose_pass);
	assign dm_wb_run    = (phase == fft_pass);
	assign tm_wb_run    = (phase == transpose_pass);
	assign step_run     = (phase == twiddle);

	assign finish_fft_process = finish_cnt[0]; // only the count of 1

endmodule

`default_nettype wire

//--- source/block_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module block_addr_counter
	import fft_ctrl_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       ce_fft,
	input  wire                       run,
	input  wire fft_size_e            fft_mode,
	output logic [`FFT_DM_ADDR_W-1:0] addr,
	output logic                      last_block
);

	logic [`FFT_DM_ADDR_W:0] blocks;

	assign blocks     = block_count(fft_mode);
	assign last_block = ({1'b0, addr} == blocks - 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			addr <= '0;
		end else if (ce_fft) begin
			if (!run) begin
				addr <= '0;
			end else if (!last_block) begin
				addr <= addr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/write_back_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module write_back_counter
	import fft_ctrl_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       ce_fft,
	input  wire                       run,
	input  wire                       stall_out,
	output logic [`FFT_DM_ADDR_W-1:0] addr,
	output logic                      wr
);

	logic stall_d;

	// core output is invalid during a stall and the cycle after it
	assign wr = run && !stall_out && !stall_d;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stall_d <= 1'b0;
			addr    <= '0;
		end else if (ce_fft) begin
			stall_d <= stall_out;
			if (!run) begin
				addr <= '0;
			end else if (wr) begin
				addr <= addr + 1'b1; // one word per accepted write
			end
		end
	end

endmodule

`default_nettype wire

//--- source/twiddle_stepper.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module twiddle_stepper
	import fft_ctrl_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       ce_fft,
	input  wire                       run,
	input  wire fft_size_e            fft_mode,
	input  wire                       done_arrange_signal,
	output logic                      ce_mul,
	output logic [`FFT_DM_ADDR_W-1:0] position,
	output logic [`FFT_DM_ADDR_W-1:0] step,
	output logic                      twiddle_done
);

	logic [`FFT_DM_ADDR_W-1:0] step_cnt;
	logic [`FFT_DM_ADDR_W-1:0] step_d1, step_d2, step_d3;
	logic done_d1, done_d2, done_d3;
	logic mul_en, mul_en_d;
	logic first_cycle;
	logic [`FFT_DM_ADDR_W:0] blocks;

	assign blocks = block_count(fft_mode);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			step_cnt    <= '0;
			mul_en      <= 1'b0;
			mul_en_d    <= 1'b0;
			first_cycle <= 1'b1;
			done_d1     <= 1'b0;
			done_d2     <= 1'b0;
			done_d3     <= 1'b0;
		end else if (ce_fft) begin
			first_cycle <= !run;
			mul_en      <= run && done_arrange_signal;
			mul_en_d    <= mul_en;
			if (!run) begin
				step_cnt <= '0;
			end else if (done_arrange_signal) begin
				step_cnt <= step_cnt + 1'b1;
			end
			done_d1 <= run && done_arrange_signal;
			done_d2 <= done_d1;
			done_d3 <= done_d2;
		end
	end

	// step count pipeline, aligned to the multiplier
	always_ff @(posedge clk) begin
		if (ce_fft) begin
			step_d1 <= step_cnt;
			step_d2 <= step_d1;
			step_d3 <= step_d2;
		end
	end

	assign step     = step_cnt;
	assign ce_mul   = run && (first_cycle || mul_en_d);
	assign position = run ? step_d3 : '0;

	// block count 16 wraps to 0 in the 4-bit step counter
	assign twiddle_done = done_d3 && (step_d2 == blocks[`FFT_DM_ADDR_W-1:0]);

endmodule

`default_nettype wire

//--- source/strobe_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module strobe_decoder
	import fft_ctrl_pkg::*;
(
	input  wire phase_e                    phase,
	input  wire fft_size_e                 fft_mode,
	input  wire [`FFT_DM_ADDR_W-1:0]       dm_blk_addr,
	input  wire [`FFT_TM_ADDR_W-1:0]       tm_blk_addr,
	input  wire [`FFT_DM_ADDR_W-1:0]       dm_wb_addr,
	input  wire                            dm_wb,
	input  wire [`FFT_TM_ADDR_W-1:0]       tm_wb_addr,
	input  wire                            tm_wb,
	input  wire [`FFT_DM_ADDR_W-1:0]       step,
	output logic                           dm_web1,
	output logic                           dm_oeb1,
	output logic                           dm_csb1,
	output logic [`FFT_DM_ADDR_W-1:0]      dm_a1,
	output logic                           dm_web2,
	output logic                           dm_oeb2,
	output logic                           dm_csb2,
	output logic [`FFT_DM_ADDR_W-1:0]      dm_a2,
	output logic                           fm_web1,
	output logic                           fm_oeb1,
	output logic                           fm_csb1,
	output logic [`FFT_DM_ADDR_W-1:0]      fm_a1,
	output logic                           tm_web1,
	output logic                           tm_oeb1,
	output logic                           tm_csb1,
	output logic [`FFT_TM_ADDR_W-1:0]      tm_a1,
	output logic                           tm_web2,
	output logic                           tm_oeb2,
	output logic                           tm_csb2,
	output logic [`FFT_TM_ADDR_W-1:0]      tm_a2,
	output logic                           stall_fft,
	output logic [`FFT_STAGE_W-1:0]        sel_fft,
	output logic [`FFT_STAGE_W-1:0]        shift_data,
	output logic                           sel_mux0,
	output logic                           sel_mux1,
	output logic                           sel_mux2,
	output logic                           sel_mux3,
	output radix_e                         mode
);

	always_comb begin
		dm_web1 = `FFT_STROBE_IDLE;
		dm_oeb1 = `FFT_STROBE_IDLE;
		dm_csb1 = `FFT_STROBE_IDLE;
		dm_a1   = '0;
		dm_web2 = `FFT_STROBE_IDLE;
		dm_oeb2 = `FFT_STROBE_IDLE;
		dm_csb2 = `FFT_STROBE_IDLE;
		dm_a2   = '0;
		fm_web1 = `FFT_STROBE_IDLE;
		fm_oeb1 = `FFT_STROBE_IDLE;
		fm_csb1 = `FFT_STROBE_IDLE;
		fm_a1   = '0;
		tm_web1 = `FFT_STROBE_IDLE;
		tm_oeb1 = `FFT_STROBE_IDLE;
		tm_csb1 = `FFT_STROBE_IDLE;
		tm_a1   = '0;
		tm_web2 = `FFT_STROBE_IDLE;
		tm_oeb2 = `FFT_STROBE_IDLE;
		tm_csb2 = `FFT_STROBE_IDLE;
		tm_a2   = '0;
		stall_fft  = 1'b1;
		sel_fft    = 7'b1111111; // all stages bypassed
		shift_data = 7'b0000000;
		sel_mux0 = 1'b0;
		sel_mux1 = 1'b0;
		sel_mux2 = 1'b0;
		sel_mux3 = 1'b0;
		mode     = radix16;

		case (phase)
			load_in: begin
				sel_mux0 = 1'b1;
				dm_web1  = 1'b0;
				dm_csb1  = 1'b0;
				dm_a1    = dm_blk_addr;
				fm_web1  = 1'b0;
				fm_csb1  = 1'b0;
				fm_a1    = dm_blk_addr;
			end
			fft_pass: begin
				stall_fft = 1'b0;
				if (fft_mode == fft64) begin
					sel_fft    = 7'b1000000; // top stage unused
					shift_data = 7'b1111110;
				end else begin
					sel_fft    = 7'b0000000;
					shift_data = 7'b1111111;
				end
				dm_oeb1 = 1'b0;
				dm_csb1 = 1'b0;
				dm_a1   = dm_blk_addr;
				if (dm_wb) begin
					dm_web2 = 1'b0;
					dm_csb2 = 1'b0;
					dm_a2   = dm_wb_addr;
				end
			end
			twiddle: begin
				mode    = size_radix(fft_mode);
				dm_oeb1 = 1'b0;
				dm_csb1 = 1'b0;
				dm_a1   = step;
				fm_oeb1 = 1'b0;
				fm_csb1 = 1'b0;
				fm_a1   = step;
			end
			transpose_pass: begin
				stall_fft = 1'b0;
				sel_mux1  = 1'b1;
				sel_mux2  = 1'b1;
				// remaining stages after the first pass
				case (fft_mode)
					fft2048: begin
						sel_fft    = 7'b1110000;
						shift_data = 7'b1111000;
					end
					fft1024: begin
						sel_fft    = 7'b1111000;
						shift_data = 7'b1110000;
					end
					fft512: begin
						sel_fft    = 7'b1111100;
						shift_data = 7'b1100000;
					end
					fft256: begin
						sel_fft    = 7'b1111110;
						shift_data = 7'b1000000;
					end
					default: begin
						sel_fft    = 7'b1111111;
						shift_data = 7'b0000000;
					end
				endcase
				tm_oeb1 = 1'b0;
				tm_csb1 = 1'b0;
				tm_a1   = tm_blk_addr;
				if (tm_wb) begin
					tm_web2 = 1'b0;
					tm_csb2 = 1'b0;
					tm_a2   = tm_wb_addr;
				end
			end
			read_out: begin
				sel_mux3 = (fft_mode >= fft256); // result sits in the transpose memory
				dm_oeb1  = 1'b0;
				dm_csb1  = 1'b0;
				dm_a1    = dm_blk_addr;
				tm_oeb1  = 1'b0;
				tm_csb1  = 1'b0;
				tm_a1    = dm_blk_addr; // shared block counter
			end
			default: begin
				stall_fft = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/fft_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module fft_ctrl_top
	import fft_ctrl_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       ce_fft,
	input  wire                       done_arrange_signal,
	input  wire                       stall_out,
	input  wire fft_size_e            fft_mode,
	output logic                      dm_web1,
	output logic                      dm_oeb1,
	output logic                      dm_csb1,
	output logic [`FFT_DM_ADDR_W-1:0] dm_a1,
	output logic                      dm_web2,
	output logic                      dm_oeb2,
	output logic                      dm_csb2,
	output logic [`FFT_DM_ADDR_W-1:0] dm_a2,
	output logic                      fm_web1,
	output logic                      fm_oeb1,
	output logic                      fm_csb1,
	output logic [`FFT_DM_ADDR_W-1:0] fm_a1,
	output logic                      tm_web1,
	output logic                      tm_oeb1,
	output logic                      tm_csb1,
	output logic [`FFT_TM_ADDR_W-1:0] tm_a1,
	output logic                      tm_web2,
	output logic                      tm_oeb2,
	output logic                      tm_csb2,
	output logic [`FFT_TM_ADDR_W-1:0] tm_a2,
	output logic                      stall_fft,
	output logic [`FFT_STAGE_W-1:0]   sel_fft,
	output logic [`FFT_STAGE_W-1:0]   shift_data,
	output logic                      sel_mux0,
	output logic                      sel_mux1,
	output logic                      sel_mux2,
	output logic                      sel_mux3,
	output logic                      ce_mul,
	output logic [1:0]                mode,
	output logic [`FFT_DM_ADDR_W-1:0] position,
	output logic                      finish_fft_process
);

	phase_e phase;
	logic dm_block_run, tm_block_run;
	logic dm_wb_run, tm_wb_run;
	logic step_run;
	logic dm_last_block;
	logic twiddle_done;
	logic [`FFT_DM_ADDR_W-1:0] dm_blk_addr;
	logic [`FFT_TM_ADDR_W-1:0] tm_blk_addr;
	logic [`FFT_DM_ADDR_W-1:0] dm_wb_addr;
	logic [`FFT_TM_ADDR_W-1:0] tm_wb_addr;
	logic dm_wb, tm_wb;
	logic [`FFT_DM_ADDR_W-1:0] step;

	phase_sequencer u_seq (
		.clk                (clk),
		.rst                (rst),
		.ce_fft             (ce_fft),
		.fft_mode           (fft_mode),
		.dm_last_block      (dm_last_block),
		.twiddle_done       (twiddle_done),
		.phase              (phase),
		.dm_block_run       (dm_block_run),
		.tm_block_run       (tm_block_run),
		.dm_wb_run          (dm_wb_run),
		.tm_wb_run          (tm_wb_run),
		.step_run           (step_run),
		.finish_fft_process (finish_fft_process)
	);

	block_addr_counter dm_block_cnt (
		.clk        (clk),
		.rst        (rst),
		.ce_fft     (ce_fft),
		.run        (dm_block_run),
		.fft_mode   (fft_mode),
		.addr       (dm_blk_addr),
		.last_block (dm_last_block)
	);

	// transpose read simply holds on the last block
	block_addr_counter tm_block_cnt (
		.clk        (clk),
		.rst        (rst),
		.ce_fft     (ce_fft),
		.run        (tm_block_run),
		.fft_mode   (fft_mode),
		.addr       (tm_blk_addr),
		.last_block ()
	);

	write_back_counter dm_wb_cnt (
		.clk       (clk),
		.rst       (rst),
		.ce_fft    (ce_fft),
		.run       (dm_wb_run),
		.stall_out (stall_out),
		.addr      (dm_wb_addr),
		.wr        (dm_wb)
	);

	write_back_counter tm_wb_cnt (
		.clk       (clk),
		.rst       (rst),
		.ce_fft    (ce_fft),
		.run       (tm_wb_run),
		.stall_out (stall_out),
		.addr      (tm_wb_addr),
		.wr        (tm_wb)
	);

	twiddle_stepper u_twiddle (
		.clk                 (clk),
		.rst                 (rst),
		.ce_fft              (ce_fft),
		.run                 (step_run),
		.fft_mode            (fft_mode),
		.done_arrange_signal (done_arrange_signal),
		.ce_mul              (ce_mul),
		.position            (position),
		.step                (step),
		.twiddle_done        (twiddle_done)
	);

	strobe_decoder u_dec (
		.phase       (phase),
		.fft_mode    (fft_mode),
		.dm_blk_addr (dm_blk_addr),
		.tm_blk_addr (tm_blk_addr),
		.dm_wb_addr  (dm_wb_addr),
		.dm_wb       (dm_wb),
		.tm_wb_addr  (tm_wb_addr),
		.tm_wb       (tm_wb),
		.step        (step),
		.dm_web1     (dm_web1),
		.dm_oeb1     (dm_oeb1),
		.dm_csb1     (dm_csb1),
		.dm_a1       (dm_a1),
		.dm_web2     (dm_web2),
		.dm_oeb2     (dm_oeb2),
		.dm_csb2     (dm_csb2),
		.dm_a2       (dm_a2),
		.fm_web1     (fm_web1),
		.fm_oeb1     (fm_oeb1),
		.fm_csb1     (fm_csb1),
		.fm_a1       (fm_a1),
		.tm_web1     (tm_web1),
		.tm_oeb1     (tm_oeb1),
		.tm_csb1     (tm_csb1),
		.tm_a1       (tm_a1),
		.tm_web2     (tm_web2),
		.tm_oeb2     (tm_oeb2),
		.tm_csb2     (tm_csb2),
		.tm_a2       (tm_a2),
		.stall_fft   (stall_fft),
		.sel_fft     (sel_fft),
		.shift_data  (shift_data),
		.sel_mux0    (sel_mux0),
		.sel_mux1    (sel_mux1),
		.sel_mux2    (sel_mux2),
		.sel_mux3    (sel_mux3),
		.mode        (mode)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	localparam time HALF_PERIOD = 50ns; // 100 ns clock

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- sim/fft_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fft_ctrl_assertions (
	input wire clk,
	input wire rst,
	input wire ce_fft,
	input wire stall_out,
	input wire dm_web1,
	input wire dm_oeb1,
	input wire dm_web2,
	input wire finish_fft_process
);

	int fail_count = 0;

	// finish is a single pulse, unless the clock enable holds it
	finish_single_pulse: assert property (@(posedge clk) disable iff (rst)
		finish_fft_process && ce_fft |=> !finish_fft_process)
	else begin
		$error("finish_fft_process stayed high for two enabled cycles");
		fail_count++;
	end

	// core output invalid for one cycle after a stall
	no_write_after_stall: assert property (@(posedge clk) disable iff (rst)
		stall_out |=> dm_web2)
	else begin
		$error("dm_web2 low in the cycle after stall_out was high");
		fail_count++;
	end

	no_read_during_write: assert property (@(posedge clk) disable iff (rst)
		!(!dm_web1 && !dm_oeb1))
	else begin
		$error("dm_web1 and dm_oeb1 both low in the same cycle");
		fail_count++;
	end

endmodule

bind fft_ctrl_top fft_ctrl_assertions u_assertions (
	.clk                (clk),
	.rst                (rst),
	.ce_fft             (ce_fft),
	.stall_out          (stall_out),
	.dm_web1            (dm_web1),
	.dm_oeb1            (dm_oeb1),
	.dm_web2            (dm_web2),
	.finish_fft_process (finish_fft_process)
);

`default_nettype wire

//--- sim/fft_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fft_ctrl_config.svh"

module fft_ctrl_tb
	import fft_ctrl_pkg::*;
();

	localparam int MAX_CYCLES = 3000;

	logic clk;
	logic rst;
	logic ce_fft;
	logic done_arrange_signal;
	logic stall_out;
	fft_size_e fft_mode;
	logic dm_web1, dm_oeb1, dm_csb1;
	logic [`FFT_DM_ADDR_W-1:0] dm_a1;
	logic dm_web2, dm_oeb2, dm_csb2;
	logic [`FFT_DM_ADDR_W-1:0] dm_a2;
	logic fm_web1, fm_oeb1, fm_csb1;
	logic [`FFT_DM_ADDR_W-1:0] fm_a1;
	logic tm_web1, tm_oeb1, tm_csb1;
	logic [`FFT_TM_ADDR_W-1:0] tm_a1;
	logic tm_web2, tm_oeb2, tm_csb2;
	logic [`FFT_TM_ADDR_W-1:0] tm_a2;
	logic stall_fft;
	logic [`FFT_STAGE_W-1:0] sel_fft;
	logic [`FFT_STAGE_W-1:0] shift_data;
	logic sel_mux0, sel_mux1, sel_mux2, sel_mux3;
	logic ce_mul;
	logic [1:0] mode;
	logic [`FFT_DM_ADDR_W-1:0] position;
	logic finish_fft_process;

	int cycle_count = 0;
	int mul_high;
	logic [31:0] rng_state;

	tb_clock_gen u_clk (.clk(clk));

	fft_ctrl_top u_dut (.*);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_equal(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: %s expected %0d actual %0d",
				test_name, what, expected, actual);
			$display("Verification failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic random_stall();
		rng_state = xorshift32(rng_state);
		return rng_state[1:0] == 2'b00; // roughly one cycle in four
	endfunction

	// leaves the run at the middle of load cycle 0
	task automatic apply_reset(input fft_size_e size);
		@(negedge clk);
		rst = 1'b1;
		ce_fft = 1'b1;
		stall_out = 1'b0;
		done_arrange_signal = 1'b0;
		fft_mode = size;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		#1;
	endtask

	task automatic advance(input logic ce, input logic stall, input logic done);
		@(negedge clk);
		ce_fft = ce;
		stall_out = stall;
		done_arrange_signal = done;
		#1; // outputs settle, sample here
	endtask

	task automatic load_order_512();
		int n;
		n = 0;
		apply_reset(fft512);
		while (dm_web1 == 1'b0) begin
			check_equal("load_512", "dm_a1", n, dm_a1);
			check_equal("load_512", "dm_csb1", 0, dm_csb1);
			check_equal("load_512", "fm_web1", 0, fm_web1);
			check_equal("load_512", "fm_csb1", 0, fm_csb1);
			check_equal("load_512", "fm_oeb1", 1, fm_oeb1);
			check_equal("load_512", "fm_a1", n, fm_a1);
			check_equal("load_512", "sel_mux0", 1, sel_mux0);
			n++;
			advance(1'b1, 1'b0, 1'b0);
		end
		check_equal("load_512", "load cycles", 4, n);
		check_equal("load_512", "stall_fft after load", 0, stall_fft);
	endtask

	task automatic run_small_size(input string name, input fft_size_e size, input int pass_len);
		int low_cycles;
		int stages;
		low_cycles = 0;
		stages = (size == fft64) ? 6 : 7; // log2 of the point count
		apply_reset(size);
		while (stall_fft == 1'b1) begin
			check_equal(name, "ce_mul in load", 0, ce_mul);
			advance(1'b1, 1'b0, 1'b0);
		end
		while (stall_fft == 1'b0) begin
			check_equal(name, "ce_mul in fft_pass", 0, ce_mul);
			check_equal(name, "active stages", stages, $countones(~sel_fft));
			check_equal(name, "top stage bypass", stages < 7, sel_fft[6]);
			check_equal(name, "shifted stages", stages, $countones(shift_data));
			low_cycles++;
			advance(1'b1, 1'b0, 1'b0);
		end
		check_equal(name, "fft_pass cycles", pass_len, low_cycles);
		check_equal(name, "finish in first read_out cycle", 0, finish_fft_process);
		advance(1'b1, 1'b0, 1'b0);
		check_equal(name, "finish in second read_out cycle", 1, finish_fft_process);
		for (int i = 0; i < 6; i++) begin
			advance(1'b1, 1'b0, 1'b0);
			check_equal(name, "finish after pulse", 0, finish_fft_process);
			check_equal(name, "ce_mul in read_out", 0, ce_mul);
			check_equal(name, "stall_fft in read_out", 1, stall_fft);
			check_equal(name, "dm_oeb1 in read_out", 0, dm_oeb1);
			check_equal(name, "tm_oeb1 in read_out", 0, tm_oeb1);
			check_equal(name, "dm_a1 in read_out", 0, dm_a1);
			check_equal(name, "tm_a1 in read_out", 0, tm_a1);
			check_equal(name, "sel_mux3 below 256", 0, sel_mux3);
		end
	endtask

	task automatic small_sizes();
		run_small_size("small_64", fft64, 9);
		run_small_size("small_128", fft128, 10);
	endtask

	task automatic write_back_gating();
		logic stall_now;
		logic stall_prev;
		logic expect_wr;
		int writes;
		int pass_cycles;
		writes = 0;
		pass_cycles = 0;
		apply_reset(fft2048);
		stall_now = 1'b0;
		stall_prev = 1'b0; // stall register cleared by reset
		while (stall_fft == 1'b1) begin
			check_equal("write_back", "dm_web2 in load", 1, dm_web2);
			stall_prev = stall_now;
			stall_now = random_stall();
			advance(1'b1, stall_now, 1'b0);
		end
		while (stall_fft == 1'b0) begin
			expect_wr = !stall_now && !stall_prev;
			check_equal("write_back", "dm_web2", !expect_wr, dm_web2);
			check_equal("write_back", "dm_csb2", !expect_wr, dm_csb2);
			check_equal("write_back", "dm_oeb1", 0, dm_oeb1);
			if (expect_wr) begin
				check_equal("write_back", "dm_a2", writes % 16, dm_a2);
				writes++;
			end
			pass_cycles++;
			stall_prev = stall_now;
			stall_now = random_stall();
			advance(1'b1, stall_now, 1'b0);
		end
		check_equal("write_back", "fft_pass cycles", 25, pass_cycles);
	endtask

	// one cycle forward, counting multiplier enables
	task automatic watch_step(input logic done);
		advance(1'b1, 1'b0, done);
		// ports the controller never enables
		check_equal("full_1024", "dm_oeb2 idle", 1, dm_oeb2);
		check_equal("full_1024", "tm_web1 idle", 1, tm_web1);
		check_equal("full_1024", "tm_oeb2 idle", 1, tm_oeb2);
		if (ce_mul) begin
			mul_high++;
			check_equal("full_1024", "mode while ce_mul", radix8, mode);
		end
	endtask

	task automatic full_run_1024();
		int low_cycles;
		mul_high = 0;
		low_cycles = 0;
		apply_reset(fft1024);
		while (stall_fft == 1'b1) watch_step(1'b0);
		while (stall_fft == 1'b0) begin
			low_cycles++;
			watch_step(1'b0);
		end
		check_equal("full_1024", "fft_pass cycles", 17, low_cycles);
		for (int pulse = 0; pulse < 8; pulse++) begin
			watch_step(1'b1);
			check_equal("full_1024", "position at pulse", pulse, position);
			repeat (3) begin
				watch_step(1'b0);
				check_equal("full_1024", "position before update", pulse, position);
			end
			watch_step(1'b0);
			if (pulse < 7) begin
				check_equal("full_1024", "position after update", pulse + 1, position);
			end
		end
		while (stall_fft == 1'b1) watch_step(1'b0);
		low_cycles = 0;
		while (stall_fft == 1'b0) begin
			check_equal("full_1024", "tm_oeb1 in transpose", 0, tm_oeb1);
			check_equal("full_1024", "tm_csb1 in transpose", 0, tm_csb1);
			check_equal("full_1024", "tm_a1 in transpose",
				(low_cycles < 7) ? low_cycles : 7, tm_a1);
			check_equal("full_1024", "sel_mux1 in transpose", 1, sel_mux1);
			check_equal("full_1024", "sel_mux2 in transpose", 1, sel_mux2);
			// three stages left after the 7-stage first pass
			check_equal("full_1024", "active stages", 3, $countones(~sel_fft));
			check_equal("full_1024", "shifted stages", 3, $countones(shift_data));
			check_equal("full_1024", "tm_web2 in transpose", 0, tm_web2);
			check_equal("full_1024", "tm_csb2 in transpose", 0, tm_csb2);
			check_equal("full_1024", "tm_a2 in transpose", low_cycles, tm_a2);
			low_cycles++;
			watch_step(1'b0);
		end
		check_equal("full_1024", "transpose cycles", 13, low_cycles);
		while (finish_fft_process == 1'b0) watch_step(1'b0);
		check_equal("full_1024", "sel_mux3 at finish", 1, sel_mux3);
		check_equal("full_1024", "dm_oeb1 at finish", 0, dm_oeb1);
		check_equal("full_1024", "tm_oeb1 at finish", 0, tm_oeb1);
		repeat (3) watch_step(1'b0);
		check_equal("full_1024", "ce_mul high cycles", 9, mul_high);
	endtask

	task automatic ce_freeze_load();
		int enabled;
		int idx;
		logic ce;
		enabled = 0;
		idx = 0;
		ce = 1'b1;
		apply_reset(fft2048);
		while (dm_web1 == 1'b0) begin
			check_equal("ce_freeze", "dm_a1", enabled, dm_a1);
			if (ce) begin
				enabled++;
			end
			idx++;
			ce = !(idx >= 6 && idx < 11); // five frozen cycles
			advance(ce, 1'b0, 1'b0);
		end
		check_equal("ce_freeze", "enabled load cycles", 16, enabled);
		check_equal("ce_freeze", "stall_fft after load", 0, stall_fft);
	endtask

	initial begin
		rst = 1'b1;
		ce_fft = 1'b1;
		done_arrange_signal = 1'b0;
		stall_out = 1'b0;
		fft_mode = fft64;
		rng_state = 32'd39;
		load_order_512();
		small_sizes();
		write_back_gating();
		full_run_1024();
		ce_freeze_load();
		if (u_dut.u_assertions.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("%0d assertion failures seen", u_dut.u_assertions.fail_count);
			$display("Verification failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/fft_ctrl_pkg.sv
source/phase_sequencer.sv
source/block_addr_counter.sv
source/write_back_counter.sv
source/twiddle_stepper.sv
source/strobe_decoder.sv
source/fft_ctrl_top.sv
sim/tb_clock_gen.sv
sim/fft_ctrl_assertions.sv
sim/fft_ctrl_tb.sv

//--- Bender.yml
package:
  name: fft_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/fft_ctrl_pkg.sv
      - source/phase_sequencer.sv
      - source/block_addr_counter.sv
      - source/write_back_counter.sv
      - source/twiddle_stepper.sv
      - source/strobe_decoder.sv
      - source/fft_ctrl_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clock_gen.sv
      - sim/fft_ctrl_assertions.sv
      - sim/fft_ctrl_tb.sv
